// File: source/cache_defs.svh
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// Cache geometry
`define CACHE_SETS 8
`define CACHE_WAYS 4
`define LINE_BYTES_LOG2 5

`define INDEX_BITS ($clog2(`CACHE_SETS))
`define WAY_BITS ($clog2(`CACHE_WAYS))
`define OFFSET_BITS (`LINE_BYTES_LOG2)
`define TAG_BITS (32 - `INDEX_BITS - `OFFSET_BITS)

// Line address, the byte address without its offset
`define LINE_ADDR_BITS (32 - `OFFSET_BITS)

// Top address nibble of the MMIO window
`define MMIO_BASE_HI 4'hF

`endif

// File: source/cacheTypesPkg.sv
`default_nettype none
`include "cache_defs.svh"

package cacheTypesPkg;

    typedef struct packed {
        logic [`TAG_BITS-1:0] tag;
        logic [`INDEX_BITS-1:0] index;
        logic [`OFFSET_BITS-1:0] offset;
    } MemAddr;

    // Location inside the data SRAM
    typedef struct packed {
        logic [32-`WAY_BITS-`INDEX_BITS-`OFFSET_BITS-1:0] pad;
        logic [`WAY_BITS-1:0] way;
        logic [`INDEX_BITS-1:0] index;
        logic [`OFFSET_BITS-1:0] offset;
    } SramAddr;

    // SRAM view on a hit, memory view otherwise
    typedef union packed {
        MemAddr mem;
        SramAddr sram;
    } AccessAddr;

    typedef struct packed {
        logic [`TAG_BITS-1:0] tag;
        logic valid;
        logic dirty;
        logic used;
    } TagEntry;

    typedef struct packed {
        logic valid;
        logic isStore;
        MemAddr addr;
    } AccessReq;

    typedef enum logic [1:0] {
        HIT,
        MMIO,
        MISS
    } AccessOutcome;

    typedef struct packed {
        logic valid;
        AccessOutcome outcome;
        AccessAddr addr;
    } AccessResp;

    typedef struct packed {
        logic [`WAY_BITS-1:0] way;
        logic [`INDEX_BITS-1:0] index;
    } LineLoc;

endpackage

`default_nettype wire

// File: source/memcTypesPkg.sv
`default_nettype none
`include "cache_defs.svh"

package memcTypesPkg;

    typedef enum logic {
        WRITEBACK,
        FILL
    } MemcOp;

    typedef struct packed {
        logic valid;
        MemcOp op;
        cacheTypesPkg::LineLoc sramLine;
        logic [`LINE_ADDR_BITS-1:0] extLine;
    } MemcCmd;

    // Line transfer request into the transfer FSM
    typedef struct packed {
        logic valid;
        logic needWriteback;
        cacheTypesPkg::LineLoc loc;
        logic [`LINE_ADDR_BITS-1:0] newLine;
        logic [`LINE_ADDR_BITS-1:0] oldLine;
    } TransferReq;

endpackage

`default_nettype wire

// File: source/cacheTagTable.sv
`timescale 1ns/1ps
`default_nettype none
`include "cache_defs.svh"

module cacheTagTable (
    input  wire clk,
    input  wire rst,
    input  wire cacheTypesPkg::MemAddr lookupAddr,
    output logic hit,
    output logic [`WAY_BITS-1:0] hitWay,
    output logic [`WAY_BITS-1:0] victimWay,
    output logic victimDirty,
    output logic [`TAG_BITS-1:0] victimTag,
    input  wire cacheTypesPkg::LineLoc hitUpdate,
    input  wire hitUpdateValid,
    input  wire hitIsStore,
    input  wire cacheTypesPkg::LineLoc fillLoc,
    input  wire [`TAG_BITS-1:0] fillTag,
    input  wire fillValid,
    input  wire cacheTypesPkg::LineLoc probeLoc,
    output cacheTypesPkg::TagEntry probeEntry,
    input  wire cacheTypesPkg::LineLoc invalLoc,
    input  wire invalValid
);
    import cacheTypesPkg::*;

    TagEntry tagTable [`CACHE_SETS][`CACHE_WAYS];

    logic freeFound;
    logic [`WAY_BITS-1:0] freeWay;
    logic [`WAY_BITS-1:0] staleWay;

    always_comb begin
        hit = 1'b0;
        hitWay = '0;
        freeFound = 1'b0;
        freeWay = '0;
        staleWay = '0;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (tagTable[lookupAddr.index][w].valid &&
                    tagTable[lookupAddr.index][w].tag == lookupAddr.tag) begin
                hit = 1'b1;
                hitWay = w[`WAY_BITS-1:0];
            end
            // Highest way wins in both scans
            if (!tagTable[lookupAddr.index][w].valid) begin
                freeFound = 1'b1;
                freeWay = w[`WAY_BITS-1:0];
            end
            if (!tagTable[lookupAddr.index][w].used)
                staleWay = w[`WAY_BITS-1:0];
        end
        victimWay = freeFound ? freeWay : staleWay;
    end

    assign victimDirty = tagTable[lookupAddr.index][victimWay].valid &&
        tagTable[lookupAddr.index][victimWay].dirty;
    assign victimTag = tagTable[lookupAddr.index][victimWay].tag;
    assign probeEntry = tagTable[probeLoc.index][probeLoc.way];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < `CACHE_SETS; s++)
                for (int w = 0; w < `CACHE_WAYS; w++)
                    tagTable[s][w] <= '0;
        end else begin
            if (hitUpdateValid) begin
                for (int w = 0; w < `CACHE_WAYS; w++)
                    tagTable[hitUpdate.index][w].used <= 1'b0;
                tagTable[hitUpdate.index][hitUpdate.way].used <= 1'b1;
                if (hitIsStore)
                    tagTable[hitUpdate.index][hitUpdate.way].dirty <= 1'b1;
            end
            if (fillValid)
                tagTable[fillLoc.index][fillLoc.way] <=
                    '{tag: fillTag, valid: 1'b1, dirty: 1'b0, used: 1'b0};
            if (invalValid)
                tagTable[invalLoc.index][invalLoc.way] <= '0;
        end
    end

    // Fills come from the transfer FSM, invalidates from the flush walk
    fillInvalDisjoint: assert property (@(posedge clk) disable iff (rst)
        !(fillValid && invalValid && fillLoc == invalLoc))
        else $error("fill and invalidate hit the same line");

endmodule

`default_nettype wire

// File: source/cacheAccess.sv
`timescale 1ns/1ps
`default_nettype none
`include "cache_defs.svh"

module cacheAccess (
    input  wire clk,
    input  wire rst,
    input  wire cacheTypesPkg::AccessReq req,
    output cacheTypesPkg::AccessResp resp,
    input  wire hit,
    input  wire [`WAY_BITS-1:0] hitWay,
    input  wire [`WAY_BITS-1:0] victimWay,
    input  wire victimDirty,
    input  wire [`TAG_BITS-1:0] victimTag,
    output cacheTypesPkg::LineLoc hitUpdate,
    output logic hitUpdateValid,
    output logic hitIsStore,
    output memcTypesPkg::TransferReq xferReq,
    input  wire xferIdle,
    input  wire flushActive
);
    import cacheTypesPkg::*;

    logic isMmio;
    logic isHit;
    logic isMiss;
    AccessOutcome outcome;
    AccessAddr nextAddr;

    always_comb begin
        isMmio = req.addr.tag[`TAG_BITS-1 -: 4] == `MMIO_BASE_HI;
        // No hits while the flush walk owns the tag table
        isHit = !isMmio && hit && !flushActive;
        isMiss = req.valid && !isMmio && !isHit;

        nextAddr.mem = req.addr;
        if (isHit) begin
            outcome = HIT;
            nextAddr.sram = '{pad: '0, way: hitWay, index: req.addr.index,
                offset: req.addr.offset};
        end else if (isMmio) begin
            outcome = MMIO;
        end else begin
            outcome = MISS;
        end

        hitUpdate = '{way: hitWay, index: req.addr.index};
        hitUpdateValid = req.valid && isHit;
        hitIsStore = req.isStore;

        // Miss without a free transfer slot is simply answered and dropped
        xferReq.valid = isMiss && xferIdle && !flushActive;
        xferReq.needWriteback = victimDirty;
        xferReq.loc = '{way: victimWay, index: req.addr.index};
        xferReq.newLine = {req.addr.tag, req.addr.index};
        xferReq.oldLine = {victimTag, req.addr.index};
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            resp.valid <= 1'b0;
        end else begin
            resp.valid <= req.valid;
        end
        resp.outcome <= outcome;
        resp.addr <= nextAddr;
    end

endmodule

`default_nettype wire

// File: source/lineTransferFsm.sv
`timescale 1ns/1ps
`default_nettype none
`include "cache_defs.svh"

module lineTransferFsm (
    input  wire clk,
    input  wire rst,
    input  wire memcTypesPkg::TransferReq accessXfer,
    input  wire memcTypesPkg::TransferReq flushXfer,
    output memcTypesPkg::MemcCmd memcCmd,
    input  wire memcDone,
    output logic xferIdle,
    output cacheTypesPkg::LineLoc fillLoc,
    output logic [`TAG_BITS-1:0] fillTag,
    output logic fillValid
);
    import cacheTypesPkg::*;
    import memcTypesPkg::*;

    typedef enum logic [1:0] {
        IDLE,
        WRITEBACK_WAIT,
        FILL_WAIT,
        FLUSH_WAIT
    } XferState;

    XferState state;
    LineLoc heldLoc;
    logic [`LINE_ADDR_BITS-1:0] heldNewLine;

    assign xferIdle = state == IDLE;
    assign fillValid = state == FILL_WAIT && memcDone;
    assign fillLoc = heldLoc;
    assign fillTag = heldNewLine[`LINE_ADDR_BITS-1 -: `TAG_BITS];

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            memcCmd.valid <= 1'b0;
        end else begin
            memcCmd.valid <= 1'b0;
            case (state)
                IDLE: begin
                    if (accessXfer.valid) begin
                        heldLoc <= accessXfer.loc;
                        heldNewLine <= accessXfer.newLine;
                        memcCmd.valid <= 1'b1;
                        memcCmd.sramLine <= accessXfer.loc;
                        if (accessXfer.needWriteback) begin
                            memcCmd.op <= WRITEBACK;
                            memcCmd.extLine <= accessXfer.oldLine;
                            state <= WRITEBACK_WAIT;
                        end else begin
                            memcCmd.op <= FILL;
                            memcCmd.extLine <= accessXfer.newLine;
                            state <= FILL_WAIT;
                        end
                    end else if (flushXfer.valid) begin
                        memcCmd.valid <= 1'b1;
                        memcCmd.op <= WRITEBACK;
                        memcCmd.sramLine <= flushXfer.loc;
                        memcCmd.extLine <= flushXfer.oldLine;
                        state <= FLUSH_WAIT;
                    end
                end
                WRITEBACK_WAIT: begin
                    // Victim is out, refill the same SRAM line
                    if (memcDone) begin
                        memcCmd.valid <= 1'b1;
                        memcCmd.op <= FILL;
                        memcCmd.sramLine <= heldLoc;
                        memcCmd.extLine <= heldNewLine;
                        state <= FILL_WAIT;
                    end
                end
                FILL_WAIT, FLUSH_WAIT: begin
                    if (memcDone)
                        state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    singleRequester: assert property (@(posedge clk) disable iff (rst)
        !(accessXfer.valid && flushXfer.valid))
        else $error("access and flush transfers requested together");

    doneOnlyWhenBusy: assert property (@(posedge clk) disable iff (rst)
        memcDone |-> state != IDLE)
        else $error("memcDone without an outstanding command");

endmodule

`default_nettype wire

// File: source/flushSequencer.sv
`timescale 1ns/1ps
`default_nettype none
`include "cache_defs.svh"

module flushSequencer (
    input  wire clk,
    input  wire rst,
    input  wire fence,
    output logic fenceBusy,
    output logic flushActive,
    output cacheTypesPkg::LineLoc probeLoc,
    input  wire cacheTypesPkg::TagEntry probeEntry,
    output cacheTypesPkg::LineLoc invalLoc,
    output logic invalValid,
    output memcTypesPkg::TransferReq flushXfer,
    input  wire xferIdle
);
    typedef enum logic [1:0] {
        IDLE,
        WAIT_IDLE,
        WALK,
        DRAIN
    } FlushState;

    FlushState state;
    logic [`INDEX_BITS+`WAY_BITS-1:0] walkPos;
    logic needWb;
    logic step;

    assign fenceBusy = state != IDLE;
    assign flushActive = fenceBusy;

    always_comb begin
        // Set in the upper bits, so all ways of a set go first
        probeLoc.index = walkPos[`INDEX_BITS+`WAY_BITS-1 -: `INDEX_BITS];
        probeLoc.way = walkPos[`WAY_BITS-1:0];
        invalLoc = probeLoc;

        needWb = probeEntry.valid && probeEntry.dirty;
        step = state == WALK && (!needWb || xferIdle);
        invalValid = step;

        flushXfer.valid = step && needWb;
        flushXfer.needWriteback = 1'b1;
        flushXfer.loc = probeLoc;
        flushXfer.newLine = '0;
        flushXfer.oldLine = {probeEntry.tag, probeLoc.index};
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            walkPos <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (fence)
                        state <= WAIT_IDLE;
                end
                WAIT_IDLE: begin
                    if (xferIdle) begin
                        walkPos <= '0;
                        state <= WALK;
                    end
                end
                WALK: begin
                    if (step) begin
                        walkPos <= walkPos + 1'b1;
                        if (&walkPos)
                            state <= DRAIN;
                    end
                end
                // Last writeback still in flight
                DRAIN: begin
                    if (xferIdle)
                        state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: source/cacheTop.sv
`timescale 1ns/1ps
`default_nettype none
`include "cache_defs.svh"

module cacheTop (
    input  wire clk,
    input  wire rst,
    input  wire cacheTypesPkg::AccessReq req,
    output cacheTypesPkg::AccessResp resp,
    input  wire fence,
    output logic fenceBusy,
    output memcTypesPkg::MemcCmd memcCmd,
    input  wire memcDone
);
    import cacheTypesPkg::*;
    import memcTypesPkg::*;

    logic hit;
    logic [`WAY_BITS-1:0] hitWay;
    logic [`WAY_BITS-1:0] victimWay;
    logic victimDirty;
    logic [`TAG_BITS-1:0] victimTag;

    LineLoc hitUpdate;
    logic hitUpdateValid;
    logic hitIsStore;

    LineLoc fillLoc;
    logic [`TAG_BITS-1:0] fillTag;
    logic fillValid;

    LineLoc probeLoc;
    TagEntry probeEntry;
    LineLoc invalLoc;
    logic invalValid;

    TransferReq accessXfer;
    TransferReq flushXfer;
    logic xferIdle;
    logic flushActive;

    cacheTagTable tagTable0 (
        .clk(clk),
        .rst(rst),
        .lookupAddr(req.addr),
        .hit(hit),
        .hitWay(hitWay),
        .victimWay(victimWay),
        .victimDirty(victimDirty),
        .victimTag(victimTag),
        .hitUpdate(hitUpdate),
        .hitUpdateValid(hitUpdateValid),
        .hitIsStore(hitIsStore),
        .fillLoc(fillLoc),
        .fillTag(fillTag),
        .fillValid(fillValid),
        .probeLoc(probeLoc),
        .probeEntry(probeEntry),
        .invalLoc(invalLoc),
        .invalValid(invalValid)
    );

    cacheAccess access0 (
        .clk(clk),
        .rst(rst),
        .req(req),
        .resp(resp),
        .hit(hit),
        .hitWay(hitWay),
        .victimWay(victimWay),
        .victimDirty(victimDirty),
        .victimTag(victimTag),
        .hitUpdate(hitUpdate),
        .hitUpdateValid(hitUpdateValid),
        .hitIsStore(hitIsStore),
        .xferReq(accessXfer),
        .xferIdle(xferIdle),
        .flushActive(flushActive)
    );

    lineTransferFsm xferFsm0 (
        .clk(clk),
        .rst(rst),
        .accessXfer(accessXfer),
        .flushXfer(flushXfer),
        .memcCmd(memcCmd),
        .memcDone(memcDone),
        .xferIdle(xferIdle),
        .fillLoc(fillLoc),
        .fillTag(fillTag),
        .fillValid(fillValid)
    );

    flushSequencer flush0 (
        .clk(clk),
        .rst(rst),
        .fence(fence),
        .fenceBusy(fenceBusy),
        .flushActive(flushActive),
        .probeLoc(probeLoc),
        .probeEntry(probeEntry),
        .invalLoc(invalLoc),
        .invalValid(invalValid),
        .flushXfer(flushXfer),
        .xferIdle(xferIdle)
    );

endmodule

`default_nettype wire

// File: verif/cacheTb.sv
`timescale 1ns/1ps
`default_nettype none
`include "cache_defs.svh"

module cacheTb;
    import cacheTypesPkg::*;
    import memcTypesPkg::*;

    logic clk;
    logic rst;
    AccessReq req;
    AccessResp resp;
    logic fence;
    logic fenceBusy;
    MemcCmd memcCmd;
    logic memcDone;

    TagEntry refTable [`CACHE_SETS][`CACHE_WAYS];
    AccessResp respQ[$];
    MemcCmd cmdQ[$];
    logic xferOpen;
    LineLoc fillLocRef;
    logic [`TAG_BITS-1:0] fillTagRef;
    int mismatches;
    int otherErrors;
    int checks;

    cacheTop dut0 (
        .clk(clk),
        .rst(rst),
        .req(req),
        .resp(resp),
        .fence(fence),
        .fenceBusy(fenceBusy),
        .memcCmd(memcCmd),
        .memcDone(memcDone)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] makeAddr(input int tag, input int index, input int offset);
        MemAddr a;
        a.tag = tag[`TAG_BITS-1:0];
        a.index = index[`INDEX_BITS-1:0];
        a.offset = offset[`OFFSET_BITS-1:0];
        return a;
    endfunction

    // Highest free way, else highest unused way, else way 0
    function automatic logic [`WAY_BITS-1:0] pickVictim(input logic [`INDEX_BITS-1:0] index);
        logic [`WAY_BITS-1:0] way;
        logic freeFound;
        way = '0;
        freeFound = 1'b0;
        for (int w = 0; w < `CACHE_WAYS; w++)
            if (!refTable[index][w].used)
                way = w[`WAY_BITS-1:0];
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (!refTable[index][w].valid) begin
                freeFound = 1'b1;
                way = w[`WAY_BITS-1:0];
            end
        end
        return way;
    endfunction

    function automatic AccessResp predictResp(input MemAddr a);
        AccessResp r;
        SramAddr s;
        r.valid = 1'b1;
        r.outcome = MISS;
        r.addr.mem = a;
        if (a.tag[`TAG_BITS-1 -: 4] == `MMIO_BASE_HI) begin
            r.outcome = MMIO;
        end else begin
            for (int w = 0; w < `CACHE_WAYS; w++) begin
                if (refTable[a.index][w].valid && refTable[a.index][w].tag == a.tag) begin
                    s = '0;
                    s.way = w[`WAY_BITS-1:0];
                    s.index = a.index;
                    s.offset = a.offset;
                    r.outcome = HIT;
                    r.addr.sram = s;
                end
            end
        end
        return r;
    endfunction

    task automatic reportMismatch(input string name, input logic [31:0] got,
            input logic [31:0] exp);
        mismatches++;
        $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    endtask

    task automatic failRun(input string why);
        $display("timeout: %s", why);
        $display("errors: %0d mismatches, %0d other failures, %0d responses checked",
            mismatches, otherErrors, checks);
        $display("TB FAILED");
        $finish;
    endtask

    task automatic access(input logic [31:0] addrWord, input logic isStore);
        MemAddr a;
        AccessResp exp;
        MemcCmd c;
        logic [`WAY_BITS-1:0] v;
        a = addrWord;
        @(negedge clk);
        exp = predictResp(a);
        if (exp.outcome == HIT) begin
            for (int w = 0; w < `CACHE_WAYS; w++)
                refTable[a.index][w].used = 1'b0;
            refTable[a.index][exp.addr.sram.way].used = 1'b1;
            if (isStore)
                refTable[a.index][exp.addr.sram.way].dirty = 1'b1;
        end else if (exp.outcome == MISS && !xferOpen) begin
            v = pickVictim(a.index);
            c.valid = 1'b1;
            c.sramLine.way = v;
            c.sramLine.index = a.index;
            if (refTable[a.index][v].valid && refTable[a.index][v].dirty) begin
                c.op = WRITEBACK;
                c.extLine = {refTable[a.index][v].tag, a.index};
                cmdQ.push_back(c);
            end
            c.op = FILL;
            c.extLine = {a.tag, a.index};
            cmdQ.push_back(c);
            fillLocRef = c.sramLine;
            fillTagRef = a.tag;
            xferOpen = 1'b1;
        end
        respQ.push_back(exp);
        req.valid = 1'b1;
        req.isStore = isStore;
        req.addr = a;
        @(negedge clk);
        req.valid = 1'b0;
    endtask

    task automatic waitIdle();
        int guard;
        guard = 0;
        while (xferOpen && guard < 200) begin
            @(negedge clk);
            guard++;
        end
        if (xferOpen)
            failRun("line transfer never completed");
    endtask

    task automatic runFence();
        int guard;
        MemcCmd c;
        @(negedge clk);
        // Writebacks expected in set-then-way order
        for (int s = 0; s < `CACHE_SETS; s++) begin
            for (int w = 0; w < `CACHE_WAYS; w++) begin
                if (refTable[s][w].valid && refTable[s][w].dirty) begin
                    c.valid = 1'b1;
                    c.op = WRITEBACK;
                    c.sramLine.way = w[`WAY_BITS-1:0];
                    c.sramLine.index = s[`INDEX_BITS-1:0];
                    c.extLine = {refTable[s][w].tag, s[`INDEX_BITS-1:0]};
                    cmdQ.push_back(c);
                end
                refTable[s][w] = '0;
            end
        end
        fence = 1'b1;
        @(negedge clk);
        fence = 1'b0;
        assert (fenceBusy) else begin
            otherErrors++;
            $display("fenceBusy did not rise after the fence at %0t", $time);
        end
        guard = 0;
        while (fenceBusy && guard < 1000) begin
            @(negedge clk);
            guard++;
        end
        if (fenceBusy)
            failRun("fenceBusy never fell");
    endtask

    always @(negedge clk) begin : compareOutputs
        AccessResp expR;
        MemcCmd expC;
        if (!rst && resp.valid) begin
            assert (respQ.size() > 0) else begin
                otherErrors++;
                $display("response without a request at %0t", $time);
            end
            if (respQ.size() > 0) begin
                expR = respQ.pop_front();
                checks++;
                assert (resp.outcome == expR.outcome)
                    else reportMismatch("resp.outcome", 32'(resp.outcome), 32'(expR.outcome));
                assert (resp.addr == expR.addr)
                    else reportMismatch("resp.addr", resp.addr, expR.addr);
            end
        end
        if (!rst && memcCmd.valid) begin
            assert (cmdQ.size() > 0) else begin
                otherErrors++;
                $display("unexpected memory command at %0t", $time);
            end
            if (cmdQ.size() > 0) begin
                expC = cmdQ.pop_front();
                assert (memcCmd.op == expC.op)
                    else reportMismatch("memcCmd.op", 32'(memcCmd.op), 32'(expC.op));
                assert (memcCmd.sramLine == expC.sramLine)
                    else reportMismatch("memcCmd.sramLine", 32'(memcCmd.sramLine),
                        32'(expC.sramLine));
                assert (memcCmd.extLine == expC.extLine)
                    else reportMismatch("memcCmd.extLine", 32'(memcCmd.extLine),
                        32'(expC.extLine));
            end
        end
    end

    // Memory controller model answering each command after 1 to 8 cycles
    always begin : memoryModel
        MemcCmd cmd;
        int delay;
        @(negedge clk);
        memcDone = 1'b0;
        if (!rst && memcCmd.valid) begin
            cmd = memcCmd;
            delay = int'($urandom_range(8, 1));
            repeat (delay - 1) @(negedge clk);
            memcDone = 1'b1;
            @(posedge clk);
            // The predicted fill lands on this edge
            if (cmd.op == FILL && xferOpen) begin
                refTable[fillLocRef.index][fillLocRef.way] = '{
                    tag: fillTagRef,
                    valid: 1'b1, dirty: 1'b0, used: 1'b0};
                xferOpen = 1'b0;
            end
        end
    end

    initial begin
        logic [31:0] addrWord;
        void'($urandom(46));
        clk = 1'b0;
        rst = 1'b1;
        fence = 1'b0;
        memcDone = 1'b0;
        req = '0;
        xferOpen = 1'b0;
        fillLocRef = '0;
        fillTagRef = '0;
        mismatches = 0;
        otherErrors = 0;
        checks = 0;
        for (int s = 0; s < `CACHE_SETS; s++)
            for (int w = 0; w < `CACHE_WAYS; w++)
                refTable[s][w] = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        assert (!resp.valid && !memcCmd.valid && !fenceBusy) else begin
            otherErrors++;
            $display("outputs not idle after reset");
        end

        // Cold miss then a storing hit
        access(32'h0000_1234, 1'b0);
        waitIdle();
        access(32'h0000_1234, 1'b1);

        // MMIO passthrough
        access(32'hF000_0040, 1'b1);
        access(32'hF123_4560, 1'b0);

        // Overfill set 2 and store to odd tags
        for (int t = 1; t <= 6; t++) begin
            access(makeAddr(t, 2, 4), 1'b0);
            waitIdle();
            access(makeAddr(t, 2, 4), t % 2 == 1);
        end

        // Second miss while a writeback and its fill are open
        access(makeAddr(7, 2, 0), 1'b0);
        access(makeAddr(9, 5, 0), 1'b0);
        waitIdle();

        runFence();
        access(32'h0000_1234, 1'b0);
        waitIdle();
        for (int t = 1; t <= 6; t++) begin
            access(makeAddr(t, 2, 4), 1'b0);
            waitIdle();
        end

        for (int i = 0; i < 300; i++) begin
            if ($urandom_range(7, 0) == 0)
                addrWord = 32'hF000_0000 | ($urandom & 32'h0FFF_FFFF);
            else
                addrWord = makeAddr(int'($urandom_range(5, 0)), int'($urandom_range(7, 0)),
                    int'($urandom_range(31, 0)));
            access(addrWord, 1'($urandom_range(1, 0)));
        end
        waitIdle();
        repeat (4) @(negedge clk);

        assert (respQ.size() == 0 && cmdQ.size() == 0) else begin
            otherErrors++;
            $display("%0d responses and %0d commands never appeared", respQ.size(), cmdQ.size());
        end
        $display("errors: %0d mismatches, %0d other failures, %0d responses checked",
            mismatches, otherErrors, checks);
        if (mismatches == 0 && otherErrors == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+source
source/cacheTypesPkg.sv
source/memcTypesPkg.sv
source/cacheTagTable.sv
source/cacheAccess.sv
source/lineTransferFsm.sv
source/flushSequencer.sv
source/cacheTop.sv
verif/cacheTb.sv

// File: Makefile
SOURCES := filelist.f $(wildcard source/*.sv source/*.svh verif/*.sv)

obj_dir/VcacheTb: $(SOURCES)
	verilator --binary --timing --assert -f filelist.f --top-module cacheTb -o VcacheTb

sim.log: obj_dir/VcacheTb
	./obj_dir/VcacheTb > sim.log 2>&1 || true

.PHONY: run clean

run: obj_dir/VcacheTb
	./obj_dir/VcacheTb > sim.log 2>&1 || true
	cat sim.log
	grep -q "^TB PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log
